//--- tb.f
src/cl_shell_pkg.sv
src/host_decode.sv
src/host_execute.sv
src/host_result.sv
src/mem_arbiter.sv
src/cl_shell_top.sv
verif/cl_shell_assertions.sv
verif/tb_cl_shell.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cl_shell
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_cl_shell.sv
// Host window and DMA use disjoint memory regions so the reference memory is order independent
`timescale 1ns/1ps

module tb_cl_shell;
  import cl_shell_pkg::*;

  localparam logic [31:0] TB_ID0         = 32'h1234_ABCD;
  localparam logic [31:0] TB_ID1         = 32'h0BAD_F00D;
  localparam logic [31:0] TB_MEM_BASE    = 32'h4000_0000;
  localparam logic [31:0] TB_DMA_BASE    = 32'h0001_0000;
  localparam int          TIMEOUT_CYCLES = 4000;

  logic             clk_main_a0;
  logic             rst_main_n_sync;
  logic             host_cyc_i;
  logic             host_stb_i;
  host_req_t        host_req_i;
  logic             host_ack_o;
  logic             host_err_o;
  logic [31:0]      host_dat_o;
  logic             dma_cyc_i;
  logic             dma_stb_i;
  wb_req_t          dma_req_i;
  logic             dma_ack_o;
  logic [31:0]      dma_dat_o;
  logic             mem_cyc_o;
  logic             mem_stb_o;
  wb_req_t          mem_req_o;
  logic             mem_ack_i;
  logic [31:0]      mem_dat_i;
  logic [LED_W-1:0] vdip_i;
  logic [LED_W-1:0] vled_o;

  logic [31:0] lfsr_q = 32'd73692;
  logic [31:0] mem_words [logic [29:0]];
  logic [31:0] ref_words [logic [29:0]];
  wb_req_t     last_mem_req;
  logic        fail_reported = 1'b0;
  logic        pass_reported = 1'b0;
  int          cycle_cnt = 0;
  int          contention_cnt = 0;
  logic        both_pend;
  logic        prev_cyc = 1'b0;
  logic        last_dma = 1'b0;
  logic        have_last = 1'b0;

  cl_shell_top #(
    .SHELL_ID0       (TB_ID0),
    .SHELL_ID1       (TB_ID1),
    .MEM_WINDOW_BASE (TB_MEM_BASE)
  ) cl_shell_top_inst (.*);

  bind cl_shell_top cl_shell_assertions cl_shell_assertions_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .host_ack_i      (host_ack_o),
    .host_err_i      (host_err_o),
    .mem_cyc_i       (mem_cyc_o),
    .mem_stb_i       (mem_stb_o),
    .mem_req_i       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .dma_cyc_i       (dma_cyc_i),
    .dma_stb_i       (dma_stb_i),
    .dma_ack_i       (dma_ack_o)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #50 clk_main_a0 = ~clk_main_a0;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r     = {r[30:0], fb};
    end
    return r;
  endfunction

  // Unwritten words read back a value tied to the full address
  function automatic logic [31:0] fill_word(logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ 32'h3C96_A55A;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] dat,
                                              logic [3:0] sel);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) r[8*b +: 8] = dat[8*b +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] ref_read(logic [31:0] adr);
    return ref_words.exists(adr[31:2]) ? ref_words[adr[31:2]] : fill_word(adr);
  endfunction

  function automatic logic [15:0] reg_addr(logic [3:0] idx);
    return {1'b0, 9'd0, idx, 2'b00};
  endfunction

  task automatic fail_run(string msg);
    fail_reported = 1'b1;
    $display(">>> FAIL");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act)
    else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  task automatic check_true(logic cond, string msg);
    assert (cond)
    else fail_run(msg);
  endtask

  // ------------------------------------------------------------
  // Bus masters, called 10 ns after a rising edge
  // ------------------------------------------------------------
  task automatic host_access(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                             input logic [3:0] sel, output logic ack, output logic err,
                             output logic [31:0] rdata, output int cycles);
    int n;
    n = 0;
    host_req_i.we    = we;
    host_req_i.addr  = addr;
    host_req_i.wdata = wdata;
    host_req_i.sel   = sel;
    host_cyc_i       = 1'b1;
    host_stb_i       = 1'b1;
    do begin
      @(posedge clk_main_a0);
      #1;
      n++;
    end while (!host_ack_o && !host_err_o && n < 200);
    if (!host_ack_o && !host_err_o) fail_run("host access was never answered");
    ack    = host_ack_o;
    err    = host_err_o;
    rdata  = host_dat_o;
    cycles = n - 1;
    #9;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    @(posedge clk_main_a0);
    #10;
  endtask

  // Register access with its fixed three-cycle response
  task automatic reg_expect(string name, logic we, logic [3:0] idx, logic [31:0] wdata,
                            logic [3:0] sel, logic exp_err, logic [31:0] exp_data);
    logic        ack;
    logic        err;
    logic [31:0] rd;
    int          cyc;
    host_access(we, reg_addr(idx), wdata, sel, ack, err, rd, cyc);
    check_value({name, "_ack"}, {31'd0, !exp_err}, {31'd0, ack});
    check_value({name, "_err"}, {31'd0, exp_err}, {31'd0, err});
    check_value({name, "_latency"}, 32'd3, cyc);
    if (!we && !exp_err) check_value(name, exp_data, rd);
  endtask

  task automatic host_mem_rw(string name, logic check_req);
    logic [14:0] off;
    logic [31:0] wd;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic        ack;
    logic        err;
    logic [31:0] rd;
    int          cyc;
    off = {13'(rand_bits(13)), 2'b00};
    wd  = rand_bits(32);
    sel = 4'(rand_bits(4));
    adr = TB_MEM_BASE + {17'd0, off};
    host_access(1'b1, {1'b1, off}, wd, sel, ack, err, rd, cyc);
    check_true(ack && !err, "host memory write was not acked");
    if (check_req) begin
      check_value({name, "_adr"}, adr, last_mem_req.adr);
      check_value({name, "_dat"}, wd, last_mem_req.dat);
      check_value({name, "_sel"}, {28'd0, sel}, {28'd0, last_mem_req.sel});
      check_value({name, "_we"}, 32'd1, {31'd0, last_mem_req.we});
    end
    ref_words[adr[31:2]] = merge_bytes(ref_read(adr), wd, sel);
    host_access(1'b0, {1'b1, off}, '0, 4'hF, ack, err, rd, cyc);
    check_true(ack && !err, "host memory read was not acked");
    check_value({name, "_read"}, ref_read(adr), rd);
  endtask

  task automatic dma_rw(string name);
    logic [31:0] adr;
    logic [31:0] wd;
    logic [3:0]  sel;
    adr = TB_DMA_BASE + {18'd0, 12'(rand_bits(12)), 2'b00};
    wd  = rand_bits(32);
    sel = 4'(rand_bits(4));
    for (int pass = 0; pass < 2; pass++) begin
      dma_req_i.we  = (pass == 0);
      dma_req_i.adr = adr;
      dma_req_i.dat = wd;
      dma_req_i.sel = (pass == 0) ? sel : 4'hF;
      dma_cyc_i     = 1'b1;
      dma_stb_i     = 1'b1;
      // Ack lasts only during the memory ack cycle, so sample mid-cycle
      do begin
        @(negedge clk_main_a0);
      end while (!dma_ack_o);
      if (pass == 0) ref_words[adr[31:2]] = merge_bytes(ref_read(adr), wd, sel);
      else check_value({name, "_read"}, ref_read(adr), dma_dat_o);
      #60;
      dma_cyc_i = 1'b0;
      dma_stb_i = 1'b0;
      @(posedge clk_main_a0);
      #10;
    end
  endtask

  // ------------------------------------------------------------
  // Memory model, 0 to 5 wait states
  // ------------------------------------------------------------
  initial begin
    int waits;
    mem_ack_i = 1'b0;
    mem_dat_i = '0;
    forever begin
      @(posedge clk_main_a0);
      #1;
      if (rst_main_n_sync && mem_cyc_o && mem_stb_o) begin
        waits = int'(rand_bits(3)) % 6;
        #9;
        repeat (waits) begin
          @(posedge clk_main_a0);
          #10;
        end
        last_mem_req = mem_req_o;
        if (mem_req_o.we) begin
          mem_words[mem_req_o.adr[31:2]] = merge_bytes(
            mem_words.exists(mem_req_o.adr[31:2]) ? mem_words[mem_req_o.adr[31:2]]
                                                   : fill_word(mem_req_o.adr),
            mem_req_o.dat, mem_req_o.sel);
          mem_dat_i = '0;
        end else begin
          mem_dat_i = mem_words.exists(mem_req_o.adr[31:2]) ? mem_words[mem_req_o.adr[31:2]]
                                                            : fill_word(mem_req_o.adr);
        end
        mem_ack_i = 1'b1;
        @(posedge clk_main_a0);
        #10;
        mem_ack_i = 1'b0;
      end
    end
  end

  // Grant alternation under contention
  always @(negedge clk_main_a0) begin
    both_pend = dma_cyc_i && dma_stb_i && cl_shell_top_inst.hreq_valid && !mem_cyc_o;
  end

  always @(posedge clk_main_a0) begin
    #1;
    if (mem_cyc_o && !prev_cyc) begin
      if (both_pend && have_last) begin
        check_true((mem_req_o.adr < TB_MEM_BASE) != last_dma, "grant did not alternate");
        contention_cnt++;
      end
      last_dma  = (mem_req_o.adr < TB_MEM_BASE);
      have_last = 1'b1;
    end
    prev_cyc = mem_cyc_o;
  end

  always @(posedge clk_main_a0) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) fail_run("timeout, the test did not finish in time");
  end

  final begin
    if (!pass_reported && !fail_reported) $display(">>> FAIL");
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] wd;
    logic [3:0]  sel;
    logic [15:0] exp_led;
    logic [15:0] dip;
    rst_main_n_sync = 1'b0;
    host_cyc_i      = 1'b0;
    host_stb_i      = 1'b0;
    host_req_i      = '0;
    dma_cyc_i       = 1'b0;
    dma_stb_i       = 1'b0;
    dma_req_i       = '0;
    vdip_i          = '0;
    exp_led         = VLED_INIT;
    repeat (16) @(posedge clk_main_a0);
    #10;
    rst_main_n_sync = 1'b1;

    // Reset state
    check_true(!host_ack_o && !host_err_o && !mem_cyc_o && !mem_stb_o && !dma_ack_o,
               "control outputs not low after reset");
    check_value("vled_reset", {16'd0, VLED_INIT}, {16'd0, vled_o});
    reg_expect("id0_read", 1'b0, REG_ID0, '0, 4'hF, 1'b0, TB_ID0);
    reg_expect("id1_read", 1'b0, REG_ID1, '0, 4'hF, 1'b0, TB_ID1);
    reg_expect("vled_read", 1'b0, REG_VLED, '0, 4'hF, 1'b0, {16'd0, VLED_INIT});

    // LED byte writes
    repeat (6) begin
      wd  = rand_bits(32);
      sel = 4'(rand_bits(4));
      if (sel[0]) exp_led[7:0] = wd[7:0];
      if (sel[1]) exp_led[15:8] = wd[15:8];
      reg_expect("vled_write", 1'b1, REG_VLED, wd, sel, 1'b0, '0);
      check_value("vled_out", {16'd0, exp_led}, {16'd0, vled_o});
      reg_expect("vled_readback", 1'b0, REG_VLED, '0, 4'hF, 1'b0, {16'd0, exp_led});
    end

    // DIP synchronizer
    repeat (3) begin
      dip    = 16'(rand_bits(16));
      vdip_i = dip;
      repeat (3) @(posedge clk_main_a0);
      #10;
      reg_expect("vdip_read", 1'b0, REG_VDIP, '0, 4'hF, 1'b0, {16'd0, dip});
    end

    // Errors leave state alone
    reg_expect("id0_write", 1'b1, REG_ID0, 32'hFFFF_FFFF, 4'hF, 1'b1, '0);
    reg_expect("vdip_write", 1'b1, REG_VDIP, 32'hFFFF_FFFF, 4'hF, 1'b1, '0);
    reg_expect("unmapped_read", 1'b0, 4'd7, '0, 4'hF, 1'b1, '0);
    reg_expect("unmapped_write", 1'b1, 4'd9, 32'h0000_1234, 4'hF, 1'b1, '0);
    reg_expect("id0_after_err", 1'b0, REG_ID0, '0, 4'hF, 1'b0, TB_ID0);
    reg_expect("vled_after_err", 1'b0, REG_VLED, '0, 4'hF, 1'b0, {16'd0, exp_led});
    check_value("vled_out_after_err", {16'd0, exp_led}, {16'd0, vled_o});

    // Memory window alone
    repeat (6) host_mem_rw("mem_window", 1'b1);

    // Host and DMA together
    fork
      repeat (8) host_mem_rw("mem_shared", 1'b0);
      begin
        // First DMA request lands in the cycle the host window request appears
        @(posedge cl_shell_top_inst.hreq_valid);
        #10;
        repeat (8) dma_rw("dma_shared");
      end
    join
    check_true(contention_cnt > 0, "no grant contention was produced");

    if (!fail_reported) begin
      pass_reported = 1'b1;
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verif/cl_shell_assertions.sv
// Port-level protocol checks for the shell; checked only while reset is released
`timescale 1ns/1ps

module cl_shell_assertions (
  input logic                  clk_main_a0,
  input logic                  rst_main_n_sync,
  input logic                  host_ack_i,
  input logic                  host_err_i,
  input logic                  mem_cyc_i,
  input logic                  mem_stb_i,
  input cl_shell_pkg::wb_req_t mem_req_i,
  input logic                  mem_ack_i,
  input logic                  dma_cyc_i,
  input logic                  dma_stb_i,
  input logic                  dma_ack_i
);
  import cl_shell_pkg::*;

  // ------------------------------------------------------------
  // Host response
  // ------------------------------------------------------------
  a_ack_err_excl: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !(host_ack_i && host_err_i))
    else $error("host ack and err asserted together");

  // ------------------------------------------------------------
  // Memory master side
  // ------------------------------------------------------------
  a_mem_req_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (mem_stb_i && !mem_ack_i) |=> $stable(mem_req_i))
    else $error("memory request changed while waiting for ack");

  // Cycle ends one clock after the memory ack
  a_mem_drop_after_ack: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (mem_stb_i && mem_ack_i) |=> (!mem_cyc_i && !mem_stb_i))
    else $error("memory cycle held past its ack");

  // DMA side
  a_dma_ack_in_stb: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    dma_ack_i |-> (dma_cyc_i && dma_stb_i))
    else $error("DMA ack without a DMA strobe");

endmodule

//--- src/cl_shell_top.sv
// Host and DMA ports are Wishbone classic single-word slaves; reset arrives already synchronous
`timescale 1ns/1ps

module cl_shell_top #(
  parameter logic [31:0] SHELL_ID0       = 32'hC0DE_0001,
  parameter logic [31:0] SHELL_ID1       = 32'h5E11_0001,
  parameter logic [31:0] MEM_WINDOW_BASE = 32'h8000_0000
) (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  // Host control port
  input  logic                            host_cyc_i,
  input  logic                            host_stb_i,
  input  cl_shell_pkg::host_req_t         host_req_i,
  output logic                            host_ack_o,
  output logic                            host_err_o,
  output logic [cl_shell_pkg::DATA_W-1:0] host_dat_o,
  // DMA master port
  input  logic                            dma_cyc_i,
  input  logic                            dma_stb_i,
  input  cl_shell_pkg::wb_req_t           dma_req_i,
  output logic                            dma_ack_o,
  output logic [cl_shell_pkg::DATA_W-1:0] dma_dat_o,
  // External memory
  output logic                            mem_cyc_o,
  output logic                            mem_stb_o,
  output cl_shell_pkg::wb_req_t           mem_req_o,
  input  logic                            mem_ack_i,
  input  logic [cl_shell_pkg::DATA_W-1:0] mem_dat_i,
  // Status
  input  logic [cl_shell_pkg::LED_W-1:0]  vdip_i,
  output logic [cl_shell_pkg::LED_W-1:0]  vled_o
);
  import cl_shell_pkg::*;

  dec_op_t   op;
  logic      op_valid;
  exec_res_t res;
  wb_req_t   hreq;
  logic      hreq_valid;
  logic      hreq_ack;
  logic      done;

  // ------------------------------------------------------------
  // Host port pipeline
  // ------------------------------------------------------------
  host_decode u_decode (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .host_cyc_i      (host_cyc_i),
    .host_stb_i      (host_stb_i),
    .host_req_i      (host_req_i),
    .done_i          (done),
    .op_o            (op),
    .op_valid_o      (op_valid)
  );

  host_execute #(
    .SHELL_ID0       (SHELL_ID0),
    .SHELL_ID1       (SHELL_ID1),
    .MEM_WINDOW_BASE (MEM_WINDOW_BASE)
  ) u_execute (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .op_i            (op),
    .op_valid_i      (op_valid),
    .vdip_i          (vdip_i),
    .vled_o          (vled_o),
    .hreq_o          (hreq),
    .hreq_valid_o    (hreq_valid),
    .hreq_ack_i      (hreq_ack),
    .mem_dat_i       (mem_dat_i),
    .res_o           (res)
  );

  host_result u_result (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .res_i           (res),
    .host_ack_o      (host_ack_o),
    .host_err_o      (host_err_o),
    .host_dat_o      (host_dat_o),
    .done_o          (done)
  );

  // Shared memory port
  mem_arbiter u_arbiter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hreq_i          (hreq),
    .hreq_valid_i    (hreq_valid),
    .hreq_ack_o      (hreq_ack),
    .dma_cyc_i       (dma_cyc_i),
    .dma_stb_i       (dma_stb_i),
    .dma_req_i       (dma_req_i),
    .dma_ack_o       (dma_ack_o),
    .dma_dat_o       (dma_dat_o),
    .mem_cyc_o       (mem_cyc_o),
    .mem_stb_o       (mem_stb_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_dat_i       (mem_dat_i)
  );

endmodule

//--- src/mem_arbiter.sv
// Two masters share one single-word memory port; grant never changes inside a transfer
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  input  cl_shell_pkg::wb_req_t           hreq_i,
  input  logic                            hreq_valid_i,
  output logic                            hreq_ack_o,
  input  logic                            dma_cyc_i,
  input  logic                            dma_stb_i,
  input  cl_shell_pkg::wb_req_t           dma_req_i,
  output logic                            dma_ack_o,
  output logic [cl_shell_pkg::DATA_W-1:0] dma_dat_o,
  output logic                            mem_cyc_o,
  output logic                            mem_stb_o,
  output cl_shell_pkg::wb_req_t           mem_req_o,
  input  logic                            mem_ack_i,
  input  logic [cl_shell_pkg::DATA_W-1:0] mem_dat_i
);
  import cl_shell_pkg::*;

  logic    active_q;
  logic    gnt_dma_q;
  logic    last_dma_q;
  logic    host_req;
  logic    dma_req;
  logic    pick_dma;
  wb_req_t mem_req_q;

  assign host_req = hreq_valid_i;
  assign dma_req  = dma_cyc_i && dma_stb_i;

  // Round robin between the two when both wait
  always_comb begin
    if (host_req && dma_req) begin
      pick_dma = !last_dma_q;
    end else begin
      pick_dma = dma_req;
    end
  end

  // ------------------------------------------------------------
  // Grant state
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      active_q   <= 1'b0;
      gnt_dma_q  <= 1'b0;
      last_dma_q <= 1'b0;
    end else if (active_q) begin
      if (mem_ack_i) begin
        active_q <= 1'b0;
      end
    end else if (host_req || dma_req) begin
      active_q   <= 1'b1;
      gnt_dma_q  <= pick_dma;
      last_dma_q <= pick_dma;
    end
  end

  // Request copied at grant, masters hold theirs until ack
  always_ff @(posedge clk_main_a0) begin
    if (!active_q && (host_req || dma_req)) begin
      mem_req_q <= pick_dma ? dma_req_i : hreq_i;
    end
  end

  assign mem_cyc_o = active_q;
  assign mem_stb_o = active_q;
  assign mem_req_o = mem_req_q;

  // Ack goes back to whoever holds the grant
  assign hreq_ack_o = active_q && !gnt_dma_q && mem_ack_i;
  assign dma_ack_o  = active_q && gnt_dma_q && mem_ack_i;
  assign dma_dat_o  = gnt_dma_q ? mem_dat_i : '0;

endmodule

//--- src/host_result.sv
// Ack and err are single-cycle pulses and read data holds until the next result
`timescale 1ns/1ps

module host_result (
  input  logic                            clk_main_a0,
  input  logic                            rst_main_n_sync,
  input  cl_shell_pkg::exec_res_t         res_i,
  output logic                            host_ack_o,
  output logic                            host_err_o,
  output logic [cl_shell_pkg::DATA_W-1:0] host_dat_o,
  output logic                            done_o
);
  import cl_shell_pkg::*;

  logic              ack_q;
  logic              err_q;
  logic [DATA_W-1:0] dat_q;

  // ------------------------------------------------------------
  // Response stage
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= res_i.valid && !res_i.err;
      err_q <= res_i.valid && res_i.err;
    end
  end

  // Read data latched with each result
  always_ff @(posedge clk_main_a0) begin
    if (res_i.valid) begin
      dat_q <= res_i.rdata;
    end
  end

  assign host_ack_o = ack_q;
  assign host_err_o = err_q;
  assign host_dat_o = dat_q;

  // Lets decode accept the next request
  assign done_o = ack_q | err_q;

endmodule

//--- src/host_execute.sv
// Memory window requests are single words held until acked; vdip_i may be asynchronous
`timescale 1ns/1ps

module host_execute #(
  parameter logic [31:0] SHELL_ID0       = 32'hC0DE_0001,
  parameter logic [31:0] SHELL_ID1       = 32'h5E11_0001,
  parameter logic [31:0] MEM_WINDOW_BASE = 32'h8000_0000
) (
  input  logic                                clk_main_a0,
  input  logic                                rst_main_n_sync,
  input  cl_shell_pkg::dec_op_t               op_i,
  input  logic                                op_valid_i,
  input  logic [cl_shell_pkg::LED_W-1:0]      vdip_i,
  output logic [cl_shell_pkg::LED_W-1:0]      vled_o,
  output cl_shell_pkg::wb_req_t               hreq_o,
  output logic                                hreq_valid_o,
  input  logic                                hreq_ack_i,
  input  logic [cl_shell_pkg::DATA_W-1:0]     mem_dat_i,
  output cl_shell_pkg::exec_res_t             res_o
);
  import cl_shell_pkg::*;

  logic [LED_W-1:0]  vled_q;
  logic [LED_W-1:0]  vdip_meta_q;
  logic [LED_W-1:0]  vdip_sync_q;
  logic              hreq_valid_q;
  wb_req_t           hreq_q;
  exec_res_t         res_q;
  logic [DATA_W-1:0] reg_rdata;

  // ------------------------------------------------------------
  // Register read mux
  // ------------------------------------------------------------
  always_comb begin
    case (op_i.idx)
      REG_ID0:  reg_rdata = SHELL_ID0;
      REG_ID1:  reg_rdata = SHELL_ID1;
      REG_VLED: reg_rdata = {{(DATA_W-LED_W){1'b0}}, vled_q};
      REG_VDIP: reg_rdata = {{(DATA_W-LED_W){1'b0}}, vdip_sync_q};
      default:  reg_rdata = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Registers, DIP sync and result
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q       <= VLED_INIT;
      vdip_meta_q  <= '0;
      vdip_sync_q  <= '0;
      hreq_valid_q <= 1'b0;
      res_q.valid  <= 1'b0;
      res_q.err    <= 1'b0;
    end else begin
      vdip_meta_q <= vdip_i;
      vdip_sync_q <= vdip_meta_q;
      res_q.valid <= 1'b0;
      if (hreq_valid_q && hreq_ack_i) begin
        // Memory window completion
        hreq_valid_q <= 1'b0;
        res_q.valid  <= 1'b1;
        res_q.err    <= 1'b0;
        res_q.rdata  <= mem_dat_i;
      end else if (op_valid_i) begin
        case (op_i.kind)
          OP_REG_RD: begin
            res_q.valid <= 1'b1;
            res_q.err   <= 1'b0;
            res_q.rdata <= reg_rdata;
          end
          OP_REG_WR: begin
            // Only the two low byte lanes reach the LED register
            if (op_i.req.sel[0]) vled_q[7:0]  <= op_i.req.wdata[7:0];
            if (op_i.req.sel[1]) vled_q[15:8] <= op_i.req.wdata[15:8];
            res_q.valid <= 1'b1;
            res_q.err   <= 1'b0;
            res_q.rdata <= '0;
          end
          OP_MEM: hreq_valid_q <= 1'b1;
          default: begin
            res_q.valid <= 1'b1;
            res_q.err   <= 1'b1;
            res_q.rdata <= '0;
          end
        endcase
      end
    end
  end

  // Window offset rebased into memory space
  always_ff @(posedge clk_main_a0) begin
    if (op_valid_i && op_i.kind == OP_MEM) begin
      hreq_q.we  <= op_i.req.we;
      hreq_q.adr <= MEM_WINDOW_BASE + {{(MEM_ADDR_W-HOST_ADDR_W+1){1'b0}}, op_i.req.addr.m.off};
      hreq_q.dat <= op_i.req.wdata;
      hreq_q.sel <= op_i.req.sel;
    end
  end

  assign vled_o       = vled_q;
  assign hreq_o       = hreq_q;
  assign hreq_valid_o = hreq_valid_q;
  assign res_o        = res_q;

endmodule

//--- src/host_decode.sv
// Accepts one host access at a time and ignores the held strobe until the result completes
`timescale 1ns/1ps

module host_decode (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  logic                    host_cyc_i,
  input  logic                    host_stb_i,
  input  cl_shell_pkg::host_req_t host_req_i,
  input  logic                    done_i,
  output cl_shell_pkg::dec_op_t   op_o,
  output logic                    op_valid_o
);
  import cl_shell_pkg::*;

  logic      busy_q;
  logic      pend_q;
  host_req_t req_q;
  dec_op_t   op_d;
  dec_op_t   op_q;
  logic      op_valid_q;

  // Capture stage
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
    end else if (busy_q) begin
      pend_q <= 1'b0;
      if (done_i) begin
        busy_q <= 1'b0;
      end
    end else if (host_cyc_i && host_stb_i) begin
      busy_q <= 1'b1;
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!busy_q && host_cyc_i && host_stb_i) begin
      req_q <= host_req_i;
    end
  end

  // Classify by window bit then by register index
  always_comb begin
    op_d      = '0;
    op_d.req  = req_q;
    op_d.idx  = req_q.addr.r.idx;
    op_d.kind = OP_BAD;
    if (req_q.addr.r.win) begin
      op_d.kind = OP_MEM;
    end else begin
      case (req_q.addr.r.idx)
        REG_VLED:                   op_d.kind = req_q.we ? OP_REG_WR : OP_REG_RD;
        REG_ID0, REG_ID1, REG_VDIP: op_d.kind = req_q.we ? OP_BAD : OP_REG_RD;
        default:                    op_d.kind = OP_BAD;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= pend_q;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (pend_q) begin
      op_q <= op_d;
    end
  end

  assign op_o       = op_q;
  assign op_valid_o = op_valid_q;

endmodule

//--- src/cl_shell_pkg.sv
// Shared widths and encodings; host addresses are 16-bit byte addresses with word-aligned registers
package cl_shell_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  parameter int HOST_ADDR_W = 16;
  parameter int DATA_W      = 32;
  parameter int SEL_W       = 4;
  parameter int MEM_ADDR_W  = 32;
  parameter int LED_W       = 16;

  parameter logic [LED_W-1:0] VLED_INIT = 16'hBEEF;

  // Register map indices
  parameter logic [3:0] REG_ID0  = 4'd0;
  parameter logic [3:0] REG_ID1  = 4'd1;
  parameter logic [3:0] REG_VLED = 4'd2;
  parameter logic [3:0] REG_VDIP = 4'd3;

  // ------------------------------------------------------------
  // Host address views
  // ------------------------------------------------------------
  typedef struct packed {
    logic       win;
    logic [8:0] rsvd;
    logic [3:0] idx;
    logic [1:0] boff;
  } reg_addr_t;

  typedef struct packed {
    logic                   win;
    logic [HOST_ADDR_W-2:0] off;
  } mem_addr_t;

  // Window bit sits in the same place in both views
  typedef union packed {
    reg_addr_t r;
    mem_addr_t m;
  } host_addr_u;

  // ------------------------------------------------------------
  // Access structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic              we;
    host_addr_u        addr;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;
  } host_req_t;

  typedef enum logic [1:0] {OP_REG_RD, OP_REG_WR, OP_MEM, OP_BAD} op_kind_e;

  typedef struct packed {
    op_kind_e   kind;
    host_req_t  req;
    logic [3:0] idx;
  } dec_op_t;

  typedef struct packed {
    logic                  we;
    logic [MEM_ADDR_W-1:0] adr;
    logic [DATA_W-1:0]     dat;
    logic [SEL_W-1:0]      sel;
  } wb_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } exec_res_t;

endpackage
